//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --assert --timing
TOP       = rv_tb
FILELIST  = verilog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- hw/rv_core.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core (
   input  logic                clk,
   input  logic                rstn,
   input  logic [`RV_XLEN-1:0] instr,
   output logic [`RV_XLEN-1:0] pc,
   output logic                halted,
   axil_if.master              bus
);

   dec_if d ();

   rv_pkg::state_e      state;
   logic [`RV_XLEN-1:0] rs1_v;
   logic [`RV_XLEN-1:0] rs2_v;
   logic [`RV_XLEN-1:0] result;
   logic [`RV_XLEN-1:0] target;
   logic [`RV_XLEN-1:0] load_data;
   logic [`RV_XLEN-1:0] pc_plus4;
   logic [`RV_XLEN-1:0] wb_data;
   logic                taken;
   logic                start;
   logic                done;
   logic                misalign;
   logic                is_mem;
   logic                is_load;
   logic                wb_we;

   rv_decoder decoder_inst (.clk(clk), .rstn(rstn), .instr(instr), .state(state), .d(d));

   rv_regfile regfile_inst (
      .clk(clk), .rstn(rstn),
      .rs1_a(d.rs1), .rs2_a(d.rs2), .rs1_v(rs1_v), .rs2_v(rs2_v),
      .we(wb_we), .waddr(d.rd), .wdata(wb_data)
   );

   rv_execute execute_inst (
      .d(d), .pc(pc), .rs1_v(rs1_v), .rs2_v(rs2_v),
      .result(result), .target(target), .taken(taken)
   );

   rv_lsu lsu_inst (
      .clk(clk), .rstn(rstn), .start(start), .d(d), .addr(result), .rs2_v(rs2_v),
      .load_data(load_data), .done(done), .misalign(misalign), .bus(bus)
   );

   assign is_load = d.op inside {rv_pkg::LB, rv_pkg::LH, rv_pkg::LW, rv_pkg::LBU, rv_pkg::LHU};
   assign is_mem  = is_load || (d.op inside {rv_pkg::SB, rv_pkg::SH, rv_pkg::SW});

   assign start    = (state == rv_pkg::EXEC);
   assign halted   = (state == rv_pkg::HALT);
   assign pc_plus4 = pc + `RV_XLEN'd4;

   ////////////////////
   // write-back select
   assign wb_we = (state == rv_pkg::WRITE) &&
                  (is_load || (d.op inside {rv_pkg::LUI, rv_pkg::ADDI, rv_pkg::ADD, rv_pkg::SUB,
                                            rv_pkg::AND, rv_pkg::OR, rv_pkg::XOR, rv_pkg::JAL}));
   assign wb_data = is_load ? load_data : (d.op == rv_pkg::JAL) ? pc_plus4 : result;

   ////////////////////
   // instruction sequence
   always_ff @(posedge clk) begin
      if (rstn) begin
         state <= rv_pkg::FETCH;
         pc    <= `RV_RESET_PC;
      end else begin
         case (state)
            rv_pkg::FETCH: state <= rv_pkg::DECODE;
            rv_pkg::DECODE: begin
               if (d.op == rv_pkg::ILLEGAL) state <= rv_pkg::HALT;
               else state <= rv_pkg::EXEC;
            end
            rv_pkg::EXEC: begin
               // bad alignment stops before any request
               if (misalign) state <= rv_pkg::HALT;
               else state <= rv_pkg::MEM;
            end
            rv_pkg::MEM: begin
               if (!is_mem || done) state <= rv_pkg::WRITE;
            end
            rv_pkg::WRITE: begin
               pc    <= taken ? target : pc_plus4;
               state <= rv_pkg::FETCH;
            end
            default: state <= rv_pkg::HALT;
         endcase
      end
   end

endmodule

//--- hw/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_decoder (
   input  logic                clk,
   input  logic                rstn,
   input  logic [`RV_XLEN-1:0] instr,
   input  rv_pkg::state_e      state,
   dec_if.dec_src              d
);

   rv_pkg::instr_u      iw;
   logic [`RV_XLEN-1:0] imm_i;
   logic [`RV_XLEN-1:0] imm_s;
   logic [`RV_XLEN-1:0] imm_b;
   logic [`RV_XLEN-1:0] imm_u;
   logic [`RV_XLEN-1:0] imm_j;

   // word held from fetch until the next fetch
   always_ff @(posedge clk) begin
      if (rstn) begin
         iw <= '0;
      end else if (state == rv_pkg::FETCH) begin
         iw <= instr;
      end
   end

   assign d.rd  = iw.r.rd[$clog2(`RV_NREGS)-1:0];
   assign d.rs1 = iw.r.rs1[$clog2(`RV_NREGS)-1:0];
   assign d.rs2 = iw.r.rs2[$clog2(`RV_NREGS)-1:0];

   ////////////////////
   // immediates
   assign imm_i = {{20{iw.r.funct7[6]}}, iw.r.funct7, iw.r.rs2};
   assign imm_s = {{20{iw.s.imm_hi[6]}}, iw.s.imm_hi, iw.s.imm_lo};
   assign imm_b = {{19{iw.s.imm_hi[6]}}, iw.s.imm_hi[6], iw.s.imm_lo[0],
                   iw.s.imm_hi[5:0], iw.s.imm_lo[4:1], 1'b0};
   assign imm_u = {iw.r.funct7, iw.r.rs2, iw.r.rs1, iw.r.funct3, 12'b0};
   assign imm_j = {{11{iw.r.funct7[6]}}, iw.r.funct7[6], iw.r.rs1, iw.r.funct3,
                   iw.r.rs2[0], iw.r.funct7[5:0], iw.r.rs2[4:1], 1'b0};

   ////////////////////
   // operation
   always_comb begin
      d.op  = rv_pkg::ILLEGAL;
      d.imm = imm_i;
      case (iw.r.opcode)
         rv_pkg::OPC_LUI: begin
            d.op  = rv_pkg::LUI;
            d.imm = imm_u;
         end
         rv_pkg::OPC_OP_IMM: begin
            if (iw.r.funct3 == 3'b000) d.op = rv_pkg::ADDI;
         end
         rv_pkg::OPC_OP: begin
            case ({iw.r.funct7, iw.r.funct3})
               {7'b0000000, 3'b000}: d.op = rv_pkg::ADD;
               {7'b0100000, 3'b000}: d.op = rv_pkg::SUB;
               {7'b0000000, 3'b100}: d.op = rv_pkg::XOR;
               {7'b0000000, 3'b110}: d.op = rv_pkg::OR;
               {7'b0000000, 3'b111}: d.op = rv_pkg::AND;
               default:              d.op = rv_pkg::ILLEGAL;
            endcase
         end
         rv_pkg::OPC_JAL: begin
            d.op  = rv_pkg::JAL;
            d.imm = imm_j;
         end
         rv_pkg::OPC_BRANCH: begin
            d.imm = imm_b;
            if (iw.r.funct3 == 3'b000) d.op = rv_pkg::BEQ;
            if (iw.r.funct3 == 3'b001) d.op = rv_pkg::BNE;
         end
         rv_pkg::OPC_LOAD: begin
            case (iw.r.funct3)
               3'b000:  d.op = rv_pkg::LB;
               3'b001:  d.op = rv_pkg::LH;
               3'b010:  d.op = rv_pkg::LW;
               3'b100:  d.op = rv_pkg::LBU;
               3'b101:  d.op = rv_pkg::LHU;
               default: d.op = rv_pkg::ILLEGAL;
            endcase
         end
         rv_pkg::OPC_STORE: begin
            d.imm = imm_s;
            case (iw.s.funct3)
               3'b000:  d.op = rv_pkg::SB;
               3'b001:  d.op = rv_pkg::SH;
               3'b010:  d.op = rv_pkg::SW;
               default: d.op = rv_pkg::ILLEGAL;
            endcase
         end
         default: d.op = rv_pkg::ILLEGAL;
      endcase
   end

endmodule

//--- hw/rv_execute.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_execute (
   dec_if.dec_snk              d,
   input  logic [`RV_XLEN-1:0] pc,
   input  logic [`RV_XLEN-1:0] rs1_v,
   input  logic [`RV_XLEN-1:0] rs2_v,
   output logic [`RV_XLEN-1:0] result,
   output logic [`RV_XLEN-1:0] target,
   output logic                taken
);

   logic [`RV_XLEN-1:0] sum_imm;
   logic                equal;

   // also the effective address of loads and stores
   assign sum_imm = rs1_v + d.imm;
   assign equal   = (rs1_v == rs2_v);

   // jal and branch share pc relative target
   assign target = pc + d.imm;

   always_comb begin
      result = sum_imm;
      taken  = 1'b0;
      case (d.op)
         rv_pkg::LUI: result = d.imm;
         rv_pkg::ADD: result = rs1_v + rs2_v;
         rv_pkg::SUB: result = rs1_v - rs2_v;
         rv_pkg::AND: result = rs1_v & rs2_v;
         rv_pkg::OR:  result = rs1_v | rs2_v;
         rv_pkg::XOR: result = rs1_v ^ rs2_v;
         rv_pkg::JAL: begin
            result = pc + `RV_XLEN'd4;
            taken  = 1'b1;
         end
         rv_pkg::BEQ: taken = equal;
         rv_pkg::BNE: taken = !equal;
         default:     result = sum_imm;
      endcase
   end

endmodule

//--- hw/rv_ifs.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

// decoded instruction fields
interface dec_if;
   logic [$clog2(`RV_NREGS)-1:0] rd;
   logic [$clog2(`RV_NREGS)-1:0] rs1;
   logic [$clog2(`RV_NREGS)-1:0] rs2;
   logic [`RV_XLEN-1:0]          imm;
   rv_pkg::op_e                  op;

   modport dec_src (output rd, rs1, rs2, imm, op);
   modport dec_snk (input rd, rs1, rs2, imm, op);
endinterface

// AXI4-Lite, five channels
interface axil_if;
   logic [`RV_XLEN-1:0]   araddr;
   logic [2:0]            arprot;
   logic                  arvalid;
   logic                  arready;
   logic [`RV_XLEN-1:0]   rdata;
   logic [1:0]            rresp;
   logic                  rvalid;
   logic                  rready;
   logic [`RV_XLEN-1:0]   awaddr;
   logic [2:0]            awprot;
   logic                  awvalid;
   logic                  awready;
   logic [`RV_XLEN-1:0]   wdata;
   logic [`RV_XLEN/8-1:0] wstrb;
   logic                  wvalid;
   logic                  wready;
   logic [1:0]            bresp;
   logic                  bvalid;
   logic                  bready;

   modport master (
      output araddr, arprot, arvalid, rready,
      output awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
      input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
   );
   modport slave (
      input  araddr, arprot, arvalid, rready,
      input  awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
      output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
   );
endinterface

//--- hw/rv_lsu.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_lsu (
   input  logic                clk,
   input  logic                rstn,
   input  logic                start,
   dec_if.dec_snk              d,
   input  logic [`RV_XLEN-1:0] addr,
   input  logic [`RV_XLEN-1:0] rs2_v,
   output logic [`RV_XLEN-1:0] load_data,
   output logic                done,
   output logic                misalign,
   axil_if.master              bus
);

   localparam logic [2:0] ls_idle = 3'd0;
   localparam logic [2:0] ls_aw_w = 3'd1;
   localparam logic [2:0] ls_b    = 3'd2;
   localparam logic [2:0] ls_ar   = 3'd3;
   localparam logic [2:0] ls_r    = 3'd4;

   logic [2:0]            st;
   logic                  is_load;
   logic                  is_store;
   logic                  is_half;
   logic                  is_word;
   logic [4:0]            lane_shift;
   logic [`RV_XLEN-1:0]   rd_shifted;
   logic [`RV_XLEN-1:0]   ext_data;
   logic [`RV_XLEN-1:0]   st_data;
   logic [`RV_XLEN/8-1:0] st_strb;
   logic                  aw_done;
   logic                  w_done;

   assign is_load  = d.op inside {rv_pkg::LB, rv_pkg::LH, rv_pkg::LW, rv_pkg::LBU, rv_pkg::LHU};
   assign is_store = d.op inside {rv_pkg::SB, rv_pkg::SH, rv_pkg::SW};
   assign is_half  = d.op inside {rv_pkg::LH, rv_pkg::LHU, rv_pkg::SH};
   assign is_word  = d.op inside {rv_pkg::LW, rv_pkg::SW};

   assign misalign = start && ((is_half && addr[0]) || (is_word && addr[1:0] != 2'b00));

   ////////////////////
   // byte lanes
   assign lane_shift = {addr[1:0], 3'b000};
   assign st_data    = rs2_v << lane_shift;
   assign rd_shifted = bus.rdata >> lane_shift;

   always_comb begin
      case (d.op)
         rv_pkg::SB: st_strb = 4'b0001 << addr[1:0];
         rv_pkg::SH: st_strb = 4'b0011 << addr[1:0];
         default:    st_strb = 4'b1111;
      endcase
   end

   always_comb begin
      case (d.op)
         rv_pkg::LB:  ext_data = {{24{rd_shifted[7]}}, rd_shifted[7:0]};
         rv_pkg::LBU: ext_data = {24'b0, rd_shifted[7:0]};
         rv_pkg::LH:  ext_data = {{16{rd_shifted[15]}}, rd_shifted[15:0]};
         rv_pkg::LHU: ext_data = {16'b0, rd_shifted[15:0]};
         default:     ext_data = bus.rdata;
      endcase
   end

   // aw and w may finish in either order
   assign aw_done = !bus.awvalid || bus.awready;
   assign w_done  = !bus.wvalid || bus.wready;

   assign done = (st == ls_b && bus.bvalid) || (st == ls_r && bus.rvalid);

   assign bus.arprot = 3'b000;
   assign bus.awprot = 3'b000;

   ////////////////////
   // control
   always_ff @(posedge clk) begin
      if (rstn) begin
         st          <= ls_idle;
         bus.arvalid <= 1'b0;
         bus.rready  <= 1'b0;
         bus.awvalid <= 1'b0;
         bus.wvalid  <= 1'b0;
         bus.bready  <= 1'b0;
      end else begin
         case (st)
            ls_idle: begin
               if (start && !misalign && is_store) begin
                  bus.awvalid <= 1'b1;
                  bus.wvalid  <= 1'b1;
                  st          <= ls_aw_w;
               end else if (start && !misalign && is_load) begin
                  bus.arvalid <= 1'b1;
                  st          <= ls_ar;
               end
            end
            ls_aw_w: begin
               if (bus.awready) bus.awvalid <= 1'b0;
               if (bus.wready) bus.wvalid <= 1'b0;
               if (aw_done && w_done) begin
                  bus.bready <= 1'b1;
                  st         <= ls_b;
               end
            end
            ls_b: begin
               if (bus.bvalid) begin
                  bus.bready <= 1'b0;
                  st         <= ls_idle;
               end
            end
            ls_ar: begin
               if (bus.arready) begin
                  bus.arvalid <= 1'b0;
                  bus.rready  <= 1'b1;
                  st          <= ls_r;
               end
            end
            ls_r: begin
               if (bus.rvalid) begin
                  bus.rready <= 1'b0;
                  st         <= ls_idle;
               end
            end
            default: st <= ls_idle;
         endcase
      end
   end

   // request payload and returned load word
   always_ff @(posedge clk) begin
      if (st == ls_idle && start) begin
         bus.araddr <= {addr[`RV_XLEN-1:2], 2'b00};
         bus.awaddr <= {addr[`RV_XLEN-1:2], 2'b00};
         bus.wdata  <= st_data;
         bus.wstrb  <= st_strb;
      end
      if (st == ls_r && bus.rvalid) begin
         load_data <= ext_data;
      end
   end

endmodule

//--- hw/rv_pkg.sv
package rv_pkg;

   // major opcodes of the supported subset
   typedef enum logic [6:0] {
      OPC_LUI    = 7'b0110111,
      OPC_OP_IMM = 7'b0010011,
      OPC_OP     = 7'b0110011,
      OPC_JAL    = 7'b1101111,
      OPC_BRANCH = 7'b1100011,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011
   } opcode_e;

   typedef enum logic [4:0] {
      LUI, ADDI, ADD, SUB, AND, OR, XOR,
      JAL, BEQ, BNE,
      LB, LH, LW, LBU, LHU,
      SB, SH, SW,
      ILLEGAL
   } op_e;

   typedef enum logic [2:0] {
      FETCH, DECODE, EXEC, MEM, WRITE, HALT
   } state_e;

   // one instruction word, two field layouts
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         opcode_e    opcode;
      } r;
      struct packed {
         logic [6:0] imm_hi;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] imm_lo;
         opcode_e    opcode;
      } s;
   } instr_u;

endpackage

//--- hw/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_regfile (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic [$clog2(`RV_NREGS)-1:0] rs1_a,
   input  logic [$clog2(`RV_NREGS)-1:0] rs2_a,
   output logic [`RV_XLEN-1:0]          rs1_v,
   output logic [`RV_XLEN-1:0]          rs2_v,
   input  logic                         we,
   input  logic [$clog2(`RV_NREGS)-1:0] waddr,
   input  logic [`RV_XLEN-1:0]          wdata
);

   logic [`RV_XLEN-1:0] regs [`RV_NREGS];

   always_ff @(posedge clk) begin
      if (rstn) begin
         for (int i = 0; i < `RV_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we && waddr != '0) begin
         regs[waddr] <= wdata;
      end
   end

   // x0 reads as zero
   assign rs1_v = (rs1_a == '0) ? '0 : regs[rs1_a];
   assign rs2_v = (rs2_a == '0) ? '0 : regs[rs2_a];

endmodule

//--- hw/rv_top.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_top (
   input  logic                  clk,
   input  logic                  rstn,
   output logic [`RV_XLEN-1:0]   pc,
   input  logic [`RV_XLEN-1:0]   instr,
   output logic                  halted,
   output logic [`RV_XLEN-1:0]   axi_araddr,
   output logic [2:0]            axi_arprot,
   output logic                  axi_arvalid,
   input  logic                  axi_arready,
   input  logic [`RV_XLEN-1:0]   axi_rdata,
   input  logic [1:0]            axi_rresp,
   input  logic                  axi_rvalid,
   output logic                  axi_rready,
   output logic [`RV_XLEN-1:0]   axi_awaddr,
   output logic [2:0]            axi_awprot,
   output logic                  axi_awvalid,
   input  logic                  axi_awready,
   output logic [`RV_XLEN-1:0]   axi_wdata,
   output logic [`RV_XLEN/8-1:0] axi_wstrb,
   output logic                  axi_wvalid,
   input  logic                  axi_wready,
   input  logic [1:0]            axi_bresp,
   input  logic                  axi_bvalid,
   output logic                  axi_bready
);

   axil_if bus ();

   rv_core core_inst (
      .clk(clk), .rstn(rstn), .instr(instr), .pc(pc), .halted(halted), .bus(bus)
   );

   // slave side of the bus to the pins
   assign axi_araddr  = bus.araddr;
   assign axi_arprot  = bus.arprot;
   assign axi_arvalid = bus.arvalid;
   assign bus.arready = axi_arready;
   assign bus.rdata   = axi_rdata;
   assign bus.rresp   = axi_rresp;
   assign bus.rvalid  = axi_rvalid;
   assign axi_rready  = bus.rready;
   assign axi_awaddr  = bus.awaddr;
   assign axi_awprot  = bus.awprot;
   assign axi_awvalid = bus.awvalid;
   assign bus.awready = axi_awready;
   assign axi_wdata   = bus.wdata;
   assign axi_wstrb   = bus.wstrb;
   assign axi_wvalid  = bus.wvalid;
   assign bus.wready  = axi_wready;
   assign bus.bresp   = axi_bresp;
   assign bus.bvalid  = axi_bvalid;
   assign axi_bready  = bus.bready;

endmodule

//--- include/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// pc value after reset
`define RV_RESET_PC 32'h0000_0000

// datapath and bus width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

`endif

//--- sim/rv_assert.sv
`timescale 1ns/1ps

module rv_assert (
   input logic        clk,
   input logic        rstn,
   input logic        arvalid,
   input logic        arready,
   input logic [31:0] araddr,
   input logic        rready,
   input logic        awvalid,
   input logic        awready,
   input logic [31:0] awaddr,
   input logic        wvalid,
   input logic        wready,
   input logic        bready
);

   // valid held until ready
   ar_hold: assert property (@(posedge clk) disable iff (rstn) arvalid && !arready |=> arvalid)
      else $error("arvalid dropped before arready");
   aw_hold: assert property (@(posedge clk) disable iff (rstn) awvalid && !awready |=> awvalid)
      else $error("awvalid dropped before awready");
   w_hold: assert property (@(posedge clk) disable iff (rstn) wvalid && !wready |=> wvalid)
      else $error("wvalid dropped before wready");

   ar_align: assert property (@(posedge clk) disable iff (rstn) arvalid |-> araddr[1:0] == 2'b00)
      else $error("unaligned read address");
   aw_align: assert property (@(posedge clk) disable iff (rstn) awvalid |-> awaddr[1:0] == 2'b00)
      else $error("unaligned write address");

   // response ready only after its requests finished
   b_late: assert property (@(posedge clk) disable iff (rstn) bready |-> !awvalid && !wvalid)
      else $error("bready raised before address and data completed");
   r_late: assert property (@(posedge clk) disable iff (rstn) rready |-> !arvalid)
      else $error("rready raised before read address accepted");

endmodule

bind rv_lsu rv_assert lsu_assert_inst (
   .clk(clk), .rstn(rstn),
   .arvalid(bus.arvalid), .arready(bus.arready), .araddr(bus.araddr), .rready(bus.rready),
   .awvalid(bus.awvalid), .awready(bus.awready), .awaddr(bus.awaddr),
   .wvalid(bus.wvalid), .wready(bus.wready), .bready(bus.bready)
);

//--- sim/rv_stimulus.txt
# P byte_addr word | S aligned_addr strobe data | E halt_pc store_count (all hex)
P 00 123450b7
P 04 67808093
P 08 10000113
P 0c 00112023
P 10 ffd00193
P 14 00308233
P 18 00412223
P 1c 401182b3
P 20 0030f333
P 24 0042e3b3
P 28 0050c433
P 2c 00512423
P 30 00612623
P 34 00712823
P 38 00812a23
P 3c 00510ca3
P 40 00510da3
P 44 00511f23
P 48 02110023
P 4c 02110123
P 50 02111223
P 54 01910483
P 58 01b14503
P 5c 01e11583
P 60 01e15603
P 64 00412683
P 68 02912423
P 6c 02a12623
P 70 02b12823
P 74 02c12a23
P 78 02d12c23
P 7c 00608463
P 80 02112e23
P 84 00408463
P 88 00409463
P 8c 02112e23
P 90 00609463
P 94 0080076f
P 98 02112e23
P 9c 02e12e23
P a0 00000000
S 100 f 12345678
S 104 f 12345675
S 108 f edcba985
S 10c f 12345678
S 110 f fffffff5
S 114 f fffffffd
S 118 2 cba98500
S 118 8 85000000
S 11c c a9850000
S 120 1 12345678
S 120 4 56780000
S 124 3 12345678
S 128 f ffffff85
S 12c f 00000085
S 130 f ffffa985
S 134 f 0000a985
S 138 f 12345675
S 13c f 00000098
E a0 12

//--- sim/rv_tb.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_tb;

   localparam int halt_limit = 5000;
   localparam int quiet_cycles = 20;

   logic                  clk = 1'b0;
   logic                  rstn = 1'b1;
   logic [`RV_XLEN-1:0]   pc;
   logic [`RV_XLEN-1:0]   instr;
   logic                  halted;
   logic [`RV_XLEN-1:0]   axi_araddr;
   logic [2:0]            axi_arprot;
   logic                  axi_arvalid;
   logic                  axi_arready = 1'b0;
   logic [`RV_XLEN-1:0]   axi_rdata = '0;
   logic [1:0]            axi_rresp = 2'b00;
   logic                  axi_rvalid = 1'b0;
   logic                  axi_rready;
   logic [`RV_XLEN-1:0]   axi_awaddr;
   logic [2:0]            axi_awprot;
   logic                  axi_awvalid;
   logic                  axi_awready = 1'b0;
   logic [`RV_XLEN-1:0]   axi_wdata;
   logic [`RV_XLEN/8-1:0] axi_wstrb;
   logic                  axi_wvalid;
   logic                  axi_wready = 1'b0;
   logic [1:0]            axi_bresp = 2'b00;
   logic                  axi_bvalid = 1'b0;
   logic                  axi_bready;

   logic [31:0] rom [64];
   logic [31:0] mem [256];
   logic [31:0] exp_addr [$];
   logic [3:0]  exp_strb [$];
   logic [31:0] exp_data [$];
   logic [31:0] exp_halt_pc = '0;
   int          exp_stores = 0;
   int          stores_seen = 0;
   int          mismatches = 0;
   int          failures = 0;
   logic [31:0] lfsr_state = 32'hc0ab_bd24;

   // slave side request capture
   logic        aw_got = 1'b0;
   logic        w_got = 1'b0;
   logic        ar_got = 1'b0;
   logic [31:0] aw_addr_q = '0;
   logic [31:0] w_data_q = '0;
   logic [3:0]  w_strb_q = '0;
   logic [31:0] ar_addr_q = '0;

   rv_top rv_top_inst (.*);

   always #20 clk = !clk;

   // instruction ROM answers pc directly
   assign instr = rom[pc[7:2]];

   ////////////////////
   // random delays
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function logic take_bit();
      lfsr_state = lfsr_next(lfsr_state);
      return lfsr_state[0];
   endfunction

   ////////////////////
   // AXI4-Lite memory model
   always @(posedge clk) begin
      if (rstn) begin
         axi_awready <= 1'b0;
         axi_wready  <= 1'b0;
         axi_bvalid  <= 1'b0;
         axi_arready <= 1'b0;
         axi_rvalid  <= 1'b0;
         aw_got      <= 1'b0;
         w_got       <= 1'b0;
         ar_got      <= 1'b0;
      end else begin
         if (axi_awready) begin
            axi_awready <= 1'b0;
            aw_addr_q   <= axi_awaddr;
            aw_got      <= 1'b1;
            check_prot("awprot", axi_awprot);
         end else if (axi_awvalid && !aw_got && take_bit()) begin
            axi_awready <= 1'b1;
         end
         if (axi_wready) begin
            axi_wready <= 1'b0;
            w_data_q   <= axi_wdata;
            w_strb_q   <= axi_wstrb;
            w_got      <= 1'b1;
         end else if (axi_wvalid && !w_got && take_bit()) begin
            axi_wready <= 1'b1;
         end
         if (axi_bvalid) begin
            if (axi_bready) axi_bvalid <= 1'b0;
         end else if (aw_got && w_got && take_bit()) begin
            for (int i = 0; i < 4; i++) begin
               if (w_strb_q[i]) mem[aw_addr_q[9:2]][8*i +: 8] <= w_data_q[8*i +: 8];
            end
            check_store(aw_addr_q, w_strb_q, w_data_q);
            aw_got     <= 1'b0;
            w_got      <= 1'b0;
            axi_bvalid <= 1'b1;
         end
         if (axi_arready) begin
            axi_arready <= 1'b0;
            ar_addr_q   <= axi_araddr;
            ar_got      <= 1'b1;
            check_prot("arprot", axi_arprot);
         end else if (axi_arvalid && !ar_got && take_bit()) begin
            axi_arready <= 1'b1;
         end
         if (axi_rvalid) begin
            if (axi_rready) axi_rvalid <= 1'b0;
         end else if (ar_got && take_bit()) begin
            axi_rdata  <= mem[ar_addr_q[9:2]];
            axi_rvalid <= 1'b1;
            ar_got     <= 1'b0;
         end
      end
   end

   task automatic check_prot(input string name, input logic [2:0] p);
      assert (p == 3'b000) else begin
         mismatches++;
         $display("MISMATCH at %0t: %s is %b, expected 000", $time, name, p);
      end
   endtask

   task automatic check_store(input logic [31:0] a, input logic [3:0] s, input logic [31:0] v);
      int idx;
      idx = stores_seen;
      stores_seen++;
      if (idx >= exp_addr.size()) begin
         failures++;
         $display("store to %h seen after the last expected store", a);
      end else begin
         assert (a == exp_addr[idx] && s == exp_strb[idx] && v == exp_data[idx])
         else begin
            mismatches++;
            $display("MISMATCH at %0t: store %0d got %h/%h/%h, expected %h/%h/%h", $time,
                     idx, a, s, v, exp_addr[idx], exp_strb[idx], exp_data[idx]);
         end
      end
   endtask

   task automatic load_stimulus();
      int          fd;
      int          n;
      string       line;
      byte         tag;
      logic [31:0] f1;
      logic [31:0] f2;
      logic [31:0] f3;
      fd = $fopen("sim/rv_stimulus.txt", "r");
      if (fd == 0) begin
         failures++;
         $display("could not open the stimulus file");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
               n = $sscanf(line, "%c %h %h %h", tag, f1, f2, f3);
               if (tag == "P") begin
                  rom[f1[7:2]] = f2;
               end else if (tag == "S") begin
                  exp_addr.push_back(f1);
                  exp_strb.push_back(f2[3:0]);
                  exp_data.push_back(f3);
               end else if (tag == "E") begin
                  exp_halt_pc = f1;
                  exp_stores  = f2;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   ////////////////////
   // main sequence
   initial begin
      int cycles;
      for (int i = 0; i < 64; i++) begin
         rom[i] = '0;
      end
      // fill pattern seeded by the word index
      for (int i = 0; i < 256; i++) begin
         mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'hc3};
      end
      load_stimulus();

      repeat (9) @(posedge clk);
      @(negedge clk);
      assert (pc == `RV_RESET_PC && !halted) else begin
         mismatches++;
         $display("MISMATCH at %0t: reset pc %h halted %b", $time, pc, halted);
      end
      assert (!axi_arvalid && !axi_awvalid && !axi_wvalid && !axi_bready && !axi_rready)
      else begin
         mismatches++;
         $display("MISMATCH at %0t: bus handshake outputs active in reset", $time);
      end
      @(posedge clk);
      rstn <= 1'b0;

      cycles = 0;
      while (!halted && cycles < halt_limit) begin
         @(negedge clk);
         cycles++;
      end
      if (!halted) begin
         failures++;
         $display("timeout: the core never halted");
      end else begin
         assert (pc == exp_halt_pc) else begin
            mismatches++;
            $display("MISMATCH at %0t: halt pc %h, expected %h", $time, pc, exp_halt_pc);
         end
         // the bus must stay quiet once halted
         cycles = 0;
         while (cycles < quiet_cycles) begin
            @(negedge clk);
            cycles++;
            assert (!axi_arvalid && !axi_awvalid && !axi_wvalid && pc == exp_halt_pc)
            else begin
               failures++;
               $display("bus activity or pc change after halt at %0t", $time);
            end
         end
         assert (stores_seen == exp_stores) else begin
            mismatches++;
            $display("MISMATCH at %0t: %0d stores, expected %0d", $time, stores_seen,
                     exp_stores);
         end
      end

      $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- verilog.f
+incdir+include
hw/rv_pkg.sv
hw/rv_ifs.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_lsu.sv
hw/rv_core.sv
hw/rv_top.sv
sim/rv_assert.sv
sim/rv_tb.sv
